/* include/memctl_defs.svh */
`ifndef MEMCTL_DEFS_SVH
`define MEMCTL_DEFS_SVH

// memory side widths
`define MEM_ADDR_W 32
`define MEM_DATA_W 32

// request array geometry
`define READ_ENTRIES 8
`define WRITE_ENTRIES 8
`define SLOT_IDX_W 3

// pending writes at which writes win over reads
`define WRITE_DRAIN 6

// apb register map, byte offsets
`define REG_ADDR 4'h0
`define REG_DATA 4'h4
`define REG_CMD 4'h8
`define REG_STATUS 4'hC

`endif

/* hw/memctl_pkg.sv */
package memctl_pkg;

	// request kind as carried from the APB CMD register to the memory port.
	// the encoding matches bit 0 of a CMD write, so the mapper can cast it directly
	typedef enum logic {
		req_read  = 1'b0,	// address only
		req_write = 1'b1	// address plus data
	} req_type_t;

endpackage

/* hw/request_mapper.sv */
`include "memctl_defs.svh"

module request_mapper (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       psel,
	input  logic                       penable,
	input  logic                       pwrite,
	input  logic [3:0]                 paddr,
	input  logic [31:0]                pwdata,
	output logic [31:0]                prdata,
	output logic                       pready,
	output logic                       pslverr,
	input  logic [`READ_ENTRIES-1:0]   read_pending_mask,
	input  logic [`WRITE_ENTRIES-1:0]  write_pending_mask,
	output logic                       enq_valid,
	output memctl_pkg::req_type_t      enq_type,
	output logic [`SLOT_IDX_W-1:0]     enq_index,
	output logic [`MEM_ADDR_W-1:0]     enq_address,
	output logic [`MEM_DATA_W-1:0]     enq_data
);

	logic [`MEM_ADDR_W-1:0] staged_address;
	logic [`MEM_DATA_W-1:0] staged_data;
	logic                   access;
	logic                   offset_ok;
	logic                   cmd_write;
	logic                   read_full;
	logic                   write_full;
	logic                   pool_full;
	logic [`SLOT_IDX_W-1:0] read_free_index;
	logic [`SLOT_IDX_W-1:0] write_free_index;
	logic [`SLOT_IDX_W:0]   read_count;
	logic [`SLOT_IDX_W:0]   write_count;
	logic [7:0]             status_q;

	assign access    = psel && penable;	// apb access phase
	assign offset_ok = paddr inside {`REG_ADDR, `REG_DATA, `REG_CMD, `REG_STATUS};
	assign cmd_write = access && pwrite && (paddr == `REG_CMD);

	assign read_full  = &read_pending_mask;
	assign write_full = &write_pending_mask;
	assign pool_full  = pwdata[0] ? write_full : read_full;	// pool picked by cmd bit 0

	// stall only a cmd write whose pool has no room
	assign pready  = !(cmd_write && pool_full);
	assign pslverr = access && !offset_ok;

	// staging registers, loaded when the write completes
	always_ff @(posedge clk) begin
		if (access && pwrite && paddr == `REG_ADDR) begin
			staged_address <= pwdata[`MEM_ADDR_W-1:0];
		end
		if (access && pwrite && paddr == `REG_DATA) begin
			staged_data <= pwdata[`MEM_DATA_W-1:0];
		end
	end

	// lowest free slot per pool, scanning down so index 0 wins
	always_comb begin
		read_free_index = '0;
		for (int i = `READ_ENTRIES - 1; i >= 0; i--) begin
			if (!read_pending_mask[i]) begin
				read_free_index = `SLOT_IDX_W'(i);
			end
		end
	end

	always_comb begin
		write_free_index = '0;
		for (int i = `WRITE_ENTRIES - 1; i >= 0; i--) begin
			if (!write_pending_mask[i]) begin
				write_free_index = `SLOT_IDX_W'(i);
			end
		end
	end

	assign enq_valid   = cmd_write && !pool_full;	// one cycle, on completion
	assign enq_type    = memctl_pkg::req_type_t'(pwdata[0]);
	assign enq_index   = pwdata[0] ? write_free_index : read_free_index;
	assign enq_address = staged_address;
	assign enq_data    = staged_data;

	// pending counts for the status register
	always_comb begin
		read_count  = '0;
		write_count = '0;
		for (int i = 0; i < `READ_ENTRIES; i++) begin
			read_count = read_count + {{`SLOT_IDX_W{1'b0}}, read_pending_mask[i]};
		end
		for (int i = 0; i < `WRITE_ENTRIES; i++) begin
			write_count = write_count + {{`SLOT_IDX_W{1'b0}}, write_pending_mask[i]};
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			status_q <= '0;
		end else begin
			status_q <= {write_count, read_count};	// writes in 7:4, reads in 3:0
		end
	end

	always_comb begin
		case (paddr)
			`REG_ADDR:   prdata = staged_address;
			`REG_DATA:   prdata = staged_data;
			`REG_STATUS: prdata = {24'd0, status_q};
			default:     prdata = '0;	// cmd is write only
		endcase
	end

endmodule

/* hw/global_array.sv */
`include "memctl_defs.svh"

module global_array (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       enq_valid,
	input  memctl_pkg::req_type_t      enq_type,
	input  logic [`SLOT_IDX_W-1:0]     enq_index,
	input  logic [`MEM_ADDR_W-1:0]     enq_address,
	input  logic [`MEM_DATA_W-1:0]     enq_data,
	input  logic                       sel_valid,
	input  memctl_pkg::req_type_t      sel_type,
	input  logic [`SLOT_IDX_W-1:0]     sel_index,
	output logic [`READ_ENTRIES-1:0]   read_pending_mask,
	output logic [`WRITE_ENTRIES-1:0]  write_pending_mask,
	output logic                       out_valid,
	output memctl_pkg::req_type_t      out_type,
	output logic [`MEM_ADDR_W-1:0]     out_address,
	output logic [`MEM_DATA_W-1:0]     out_data
);

	// read pool keeps addresses only
	logic [`MEM_ADDR_W-1:0] read_addr  [`READ_ENTRIES];
	// write pool keeps address and data
	logic [`MEM_ADDR_W-1:0] write_addr [`WRITE_ENTRIES];
	logic [`MEM_DATA_W-1:0] write_data [`WRITE_ENTRIES];

	logic enq_read;
	logic enq_write;
	logic sel_read;
	logic sel_write;

	assign enq_read  = enq_valid && (enq_type == memctl_pkg::req_read);
	assign enq_write = enq_valid && (enq_type == memctl_pkg::req_write);
	assign sel_read  = sel_valid && (sel_type == memctl_pkg::req_read);
	assign sel_write = sel_valid && (sel_type == memctl_pkg::req_write);

	// valid bits; enqueue targets a free slot and selection a pending one,
	// so both can act in the same cycle without touching the same bit
	always_ff @(posedge clk) begin
		if (rst) begin
			read_pending_mask  <= '0;
			write_pending_mask <= '0;
		end else begin
			if (enq_read) begin
				read_pending_mask[enq_index] <= 1'b1;
			end
			if (enq_write) begin
				write_pending_mask[enq_index] <= 1'b1;
			end
			if (sel_read) begin
				read_pending_mask[sel_index] <= 1'b0;
			end
			if (sel_write) begin
				write_pending_mask[sel_index] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (enq_read) begin
			read_addr[enq_index] <= enq_address;
		end
		if (enq_write) begin
			write_addr[enq_index] <= enq_address;
			write_data[enq_index] <= enq_data;
		end
	end

	// output register, valid for one cycle after a selection
	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= sel_valid;
		end
	end

	always_ff @(posedge clk) begin
		if (sel_valid) begin
			out_type <= sel_type;
			if (sel_type == memctl_pkg::req_write) begin
				out_address <= write_addr[sel_index];
				out_data    <= write_data[sel_index];
			end else begin
				out_address <= read_addr[sel_index];
				out_data    <= '0;	// reads carry no data
			end
		end
	end

endmodule

/* hw/request_scheduler.sv */
`include "memctl_defs.svh"

module request_scheduler (
	input  logic                       clk,
	input  logic                       rst,
	input  logic [`READ_ENTRIES-1:0]   read_pending_mask,
	input  logic [`WRITE_ENTRIES-1:0]  write_pending_mask,
	input  logic                       slot_free,
	output logic                       sel_valid,
	output memctl_pkg::req_type_t      sel_type,
	output logic [`SLOT_IDX_W-1:0]     sel_index
);

	logic                   in_flight;
	logic                   read_any;
	logic                   write_any;
	logic                   serve_write;
	logic [`SLOT_IDX_W:0]   write_count;
	logic [`SLOT_IDX_W-1:0] read_first;
	logic [`SLOT_IDX_W-1:0] write_first;

	assign read_any  = |read_pending_mask;
	assign write_any = |write_pending_mask;

	// lowest pending index per pool and the pending write count
	always_comb begin
		read_first = '0;
		for (int i = `READ_ENTRIES - 1; i >= 0; i--) begin
			if (read_pending_mask[i]) begin
				read_first = `SLOT_IDX_W'(i);
			end
		end
	end

	always_comb begin
		write_first = '0;
		write_count = '0;
		for (int i = `WRITE_ENTRIES - 1; i >= 0; i--) begin
			if (write_pending_mask[i]) begin
				write_first = `SLOT_IDX_W'(i);
			end
			write_count = write_count + {{`SLOT_IDX_W{1'b0}}, write_pending_mask[i]};
		end
	end

	// reads first unless writes have piled up or no read waits
	assign serve_write = write_any && ((write_count >= `WRITE_DRAIN) || !read_any);

	// array output cycle, holding register not yet loaded
	always_ff @(posedge clk) begin
		if (rst) begin
			in_flight <= 1'b0;
		end else begin
			in_flight <= sel_valid;
		end
	end

	assign sel_valid = slot_free && !in_flight && (read_any || write_any);
	assign sel_type  = serve_write ? memctl_pkg::req_write : memctl_pkg::req_read;
	assign sel_index = serve_write ? write_first : read_first;

endmodule

/* hw/memory_issue.sv */
`include "memctl_defs.svh"

module memory_issue (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   out_valid,
	input  memctl_pkg::req_type_t  out_type,
	input  logic [`MEM_ADDR_W-1:0] out_address,
	input  logic [`MEM_DATA_W-1:0] out_data,
	output logic                   slot_free,
	output logic                   mem_valid,
	output memctl_pkg::req_type_t  mem_type,
	output logic [`MEM_ADDR_W-1:0] mem_address,
	output logic [`MEM_DATA_W-1:0] mem_data,
	input  logic                   mem_ready
);

	logic held;	// holding register full

	// scheduler never loads a full register, so load and drain never overlap
	always_ff @(posedge clk) begin
		if (rst) begin
			held <= 1'b0;
		end else if (out_valid) begin
			held <= 1'b1;
		end else if (held && mem_ready) begin
			held <= 1'b0;	// handshake done
		end
	end

	// payload only changes on a load, which keeps it stable during a stall
	always_ff @(posedge clk) begin
		if (out_valid) begin
			mem_type    <= out_type;
			mem_address <= out_address;
			mem_data    <= out_data;
		end
	end

	assign mem_valid = held;
	assign slot_free = !held;

endmodule

/* hw/memctl_top.sv */
`include "memctl_defs.svh"

module memctl_top (
	input  logic                   clk,
	input  logic                   rst,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [3:0]             paddr,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic                   mem_valid,
	output memctl_pkg::req_type_t  mem_type,
	output logic [`MEM_ADDR_W-1:0] mem_address,
	output logic [`MEM_DATA_W-1:0] mem_data,
	input  logic                   mem_ready
);

	logic [`READ_ENTRIES-1:0]  read_pending_mask;
	logic [`WRITE_ENTRIES-1:0] write_pending_mask;
	logic                      enq_valid;
	memctl_pkg::req_type_t     enq_type;
	logic [`SLOT_IDX_W-1:0]    enq_index;
	logic [`MEM_ADDR_W-1:0]    enq_address;
	logic [`MEM_DATA_W-1:0]    enq_data;
	logic                      sel_valid;
	memctl_pkg::req_type_t     sel_type;
	logic [`SLOT_IDX_W-1:0]    sel_index;
	logic                      out_valid;
	memctl_pkg::req_type_t     out_type;
	logic [`MEM_ADDR_W-1:0]    out_address;
	logic [`MEM_DATA_W-1:0]    out_data;
	logic                      slot_free;

	request_mapper u_mapper (
		.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.read_pending_mask, .write_pending_mask,
		.enq_valid, .enq_type, .enq_index, .enq_address, .enq_data
	);

	global_array u_array (
		.clk, .rst,
		.enq_valid, .enq_type, .enq_index, .enq_address, .enq_data,
		.sel_valid, .sel_type, .sel_index,
		.read_pending_mask, .write_pending_mask,
		.out_valid, .out_type, .out_address, .out_data
	);

	request_scheduler u_scheduler (
		.clk, .rst, .read_pending_mask, .write_pending_mask, .slot_free,
		.sel_valid, .sel_type, .sel_index
	);

	memory_issue u_issue (
		.clk, .rst, .out_valid, .out_type, .out_address, .out_data,
		.slot_free, .mem_valid, .mem_type, .mem_address, .mem_data, .mem_ready
	);

endmodule

/* testbench/memctl_tb.sv */
`include "memctl_defs.svh"

module memctl_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int num_random = 240;
	localparam int num_directed = 22;	// drain, status and back-pressure phases
	localparam int cycle_limit = 40 * (num_random + num_directed) + 2000;

	logic                   clk;
	logic                   rst;
	logic                   psel;
	logic                   penable;
	logic                   pwrite;
	logic [3:0]             paddr;
	logic [31:0]            pwdata;
	logic [31:0]            prdata;
	logic                   pready;
	logic                   pslverr;
	logic                   mem_valid;
	memctl_pkg::req_type_t  mem_type;
	logic [`MEM_ADDR_W-1:0] mem_address;
	logic [`MEM_DATA_W-1:0] mem_data;
	logic                   mem_ready;

	logic [31:0] rng_state = 32'd20982;
	logic        ready_random;	// random mem_ready, else ready_level
	logic        ready_level;
	int          wait_cycles;	// pready low cycles of the last access
	logic [31:0] last_rdata;
	logic        last_slverr;
	int          req_count;
	int          cycle_count;

	// reference model, accepted but not yet handed to memory
	logic [31:0]           read_q[$];
	logic [31:0]           write_addr_q[$];
	logic [31:0]           write_data_q[$];
	memctl_pkg::req_type_t port_log[$];	// types in port order

	logic                   prev_stall;
	memctl_pkg::req_type_t  prev_type;
	logic [`MEM_ADDR_W-1:0] prev_address;
	logic [`MEM_DATA_W-1:0] prev_data;

	memctl_top DUT (
		.clk, .rst, .psel, .penable, .pwrite, .paddr, .pwdata,
		.prdata, .pready, .pslverr,
		.mem_valid, .mem_type, .mem_address, .mem_data, .mem_ready
	);

	function automatic logic [31:0] next_random();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return rng_state;
	endfunction

	task automatic stop_run(input string line);
		$display("%s", line);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic report_mismatch(input string msg);
		stop_run($sformatf("mismatch at %0d ns: %s", $time, msg));
	endtask

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	// setup cycle, then access phase until pready, sampled before the edge
	task automatic apb_access(input logic write, input logic [3:0] addr, input logic [31:0] data);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		step();
		penable = 1'b1;
		wait_cycles = 0;
		#2;
		while (!pready) begin
			wait_cycles++;
			@(posedge clk);
			#3;
		end
		last_rdata = prdata;
		last_slverr = pslverr;
		step();
		psel = 1'b0;
		penable = 1'b0;
	endtask

	task automatic send_request(input memctl_pkg::req_type_t kind, input logic [31:0] addr,
			input logic [31:0] data);
		apb_access(1'b1, `REG_ADDR, addr);
		if (kind == memctl_pkg::req_write) begin
			apb_access(1'b1, `REG_DATA, data);
		end
		apb_access(1'b1, `REG_CMD, {31'd0, kind});
		assert (!last_slverr) else report_mismatch("pslverr set on a CMD write");
		if (kind == memctl_pkg::req_write) begin
			write_addr_q.push_back(addr);
			write_data_q.push_back(data);
		end else begin
			read_q.push_back(addr);
		end
	endtask

	task automatic send_random(input memctl_pkg::req_type_t kind);
		logic [31:0] r;
		logic [31:0] addr;
		r = next_random();
		addr = {r[31:16], req_count[15:0]};	// low half keeps addresses unique
		req_count++;
		send_request(kind, addr, next_random());
	endtask

	task automatic hold_ready(input logic level);
		ready_random = 1'b0;
		ready_level = level;
		step();
		step();
	endtask

	task automatic wait_drained();
		while (read_q.size() != 0 || write_addr_q.size() != 0 || mem_valid) begin
			step();
		end
	endtask

	task automatic check_status(input int exp_reads, input int exp_writes);
		apb_access(1'b0, `REG_STATUS, 32'd0);
		assert (last_rdata == {24'd0, exp_writes[3:0], exp_reads[3:0]}) else
			report_mismatch($sformatf("status %h, expected %0d reads and %0d writes",
				last_rdata, exp_reads, exp_writes));
	endtask

	// pool order is by slot index, so look the address up in the model
	task automatic match_port();
		int found;
		found = -1;
		if (mem_type == memctl_pkg::req_read) begin
			foreach (read_q[i]) begin
				if (read_q[i] == mem_address) begin
					found = i;
				end
			end
			assert (found >= 0) else report_mismatch($sformatf("unexpected read %h", mem_address));
			assert (mem_data == '0) else report_mismatch("read carries nonzero data");
			read_q.delete(found);
		end else begin
			foreach (write_addr_q[i]) begin
				if (write_addr_q[i] == mem_address) begin
					found = i;
				end
			end
			assert (found >= 0) else report_mismatch($sformatf("unexpected write %h", mem_address));
			assert (mem_data == write_data_q[found]) else
				report_mismatch($sformatf("write %h data %h", mem_address, mem_data));
			write_addr_q.delete(found);
			write_data_q.delete(found);
		end
		port_log.push_back(mem_type);
	endtask

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	// next level picked at the edge, driven 1 ns later
	initial begin
		logic next_ready;
		mem_ready = 1'b0;
		forever begin
			@(posedge clk);
			if (ready_random) begin
				next_ready = (next_random() % 32'd10) < 32'd6;	// about 60% high
			end else begin
				next_ready = ready_level;
			end
			#1;
			mem_ready = next_ready;
		end
	end

	initial begin
		cycle_count = 0;
		forever begin
			@(posedge clk);
			cycle_count++;
			if (cycle_count >= cycle_limit) begin
				stop_run($sformatf("run timed out after %0d cycles", cycle_count));
			end
		end
	end

	// memory port scoreboard and stall stability
	initial begin
		prev_stall = 1'b0;
		forever begin
			@(posedge clk);
			#3;
			if (!rst) begin
				if (prev_stall) begin
					assert (mem_valid && mem_type == prev_type && mem_address == prev_address &&
						mem_data == prev_data) else report_mismatch("mem outputs moved in a stall");
				end
				if (mem_valid && mem_ready) begin
					match_port();
				end
				prev_stall = mem_valid && !mem_ready;
				prev_type = mem_type;
				prev_address = mem_address;
				prev_data = mem_data;
			end
		end
	end

	initial begin
		logic [31:0] r;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		ready_random = 1'b0;
		ready_level = 1'b0;
		req_count = 0;
		wait_cycles = 0;
		repeat (8) step();
		rst = 1'b0;
		step();

		assert (!mem_valid) else report_mismatch("mem_valid high after reset");
		check_status(0, 0);
		apb_access(1'b0, 4'h2, 32'd0);
		assert (last_slverr) else report_mismatch("unmapped offset gave no pslverr");

		// writes at the drain level win over a waiting read
		hold_ready(1'b0);
		send_random(memctl_pkg::req_read);
		while (!mem_valid) step();
		repeat (`WRITE_DRAIN) send_random(memctl_pkg::req_write);
		send_random(memctl_pkg::req_read);
		repeat (4) step();
		check_status(read_q.size() - 1, write_addr_q.size());	// one read held
		port_log.delete();
		ready_level = 1'b1;
		wait_drained();
		assert (port_log.size() == `WRITE_DRAIN + 2 && port_log[1] == memctl_pkg::req_write) else
			report_mismatch("write drain did not put a write second");

		// below the drain level the read goes first
		hold_ready(1'b0);
		send_random(memctl_pkg::req_write);
		while (!mem_valid) step();
		repeat (2) send_random(memctl_pkg::req_write);
		send_random(memctl_pkg::req_read);
		repeat (4) step();
		check_status(read_q.size(), write_addr_q.size() - 1);
		port_log.delete();
		ready_level = 1'b1;
		wait_drained();
		assert (port_log.size() == 4 && port_log[1] == memctl_pkg::req_read) else
			report_mismatch("read was not served second below the drain level");

		// back-pressure, pool plus holding register full
		hold_ready(1'b0);
		while (read_q.size() < `READ_ENTRIES + 1) begin
			send_random(memctl_pkg::req_read);
		end
		repeat (2) step();
		fork
			send_random(memctl_pkg::req_read);
			begin
				repeat (24) step();
				ready_level = 1'b1;
			end
		join
		assert (wait_cycles >= 20) else
			report_mismatch($sformatf("CMD stalled only %0d cycles", wait_cycles));
		wait_drained();

		ready_random = 1'b1;
		repeat (num_random) begin
			r = next_random();
			send_random(memctl_pkg::req_type_t'(r[0]));
		end
		wait_drained();
		check_status(0, 0);

		$display("Testbench passed");
		$finish;
	end

endmodule

/* all.f */
+incdir+include
hw/memctl_pkg.sv
hw/request_mapper.sv
hw/global_array.sv
hw/request_scheduler.sv
hw/memory_issue.sv
hw/memctl_top.sv
testbench/memctl_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = memctl_tb
FILELIST  = all.f
OBJDIR    = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)
